// File: source/attn_cfg.svh
// --------------------------------------------------
// Lane count and fixed-point widths for the row datapath
// Lanes are Q9.17 and scores Q4.4
// --------------------------------------------------
`ifndef ATTN_CFG_SVH
`define ATTN_CFG_SVH

// Value lanes per token, not counting the denominator lane
`define VEC_LANES 4

// Lane width and its fractional bits
`define LANE_W 26
`define LANE_FRAC 17

// Score width in Q4.4
`define SCORE_W 8

`endif

// File: source/attn_pkg.sv
// --------------------------------------------------
// Shared datapath types for the row accumulator
// Widths follow attn_cfg.svh
// --------------------------------------------------
`default_nettype none
`include "attn_cfg.svh"

package attn_pkg;

    // Q4.4 attention score
    typedef logic signed [`SCORE_W-1:0] score_t;

    // Q5.4 score difference, one guard bit over the score
    typedef logic signed [`SCORE_W:0] diff_t;

    // Q6.4 approximation of d * log2(e)
    typedef logic signed [`SCORE_W+1:0] log2e_t;

    // Right-shift amount L, saturates at 31
    typedef logic [4:0] shift_t;

    // One Q9.17 lane
    typedef logic signed [`LANE_W-1:0] lane_t;

    // Value lanes plus the denominator lane on top
    typedef lane_t [`VEC_LANES:0] lane_vec_t;

    // Accumulator control
    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        HAND_OFF
    } acc_state_t;

endpackage

`default_nettype wire

// File: source/token_intake.sv
// --------------------------------------------------
// One-entry token buffer that tracks the row maximum
// The top input lane is ignored and replaced by 1.0
// --------------------------------------------------
`default_nettype none
`include "attn_cfg.svh"

module token_intake
    import attn_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      in_valid,
    output logic           in_ready,
    input  wire score_t    in_score,
    input  wire lane_vec_t in_value,
    input  wire logic      in_last,
    output logic           tok_valid,
    input  wire logic      tok_ready,
    output score_t         tok_score,
    output score_t         tok_max_old,
    output score_t         tok_max_new,
    output lane_vec_t      tok_value,
    output logic           tok_first,
    output logic           tok_last
);

    // 1.0 in Q9.17 for the denominator lane
    localparam lane_t LANE_ONE = lane_t'(1) <<< `LANE_FRAC;

    logic      row_open;
    score_t    row_max;
    logic      take;
    logic      first;
    score_t    max_new;
    lane_vec_t value_in;

    // Empty, or the held token leaves this cycle
    assign in_ready = !tok_valid || tok_ready;
    assign take = in_valid && in_ready;

    // No token of the current row seen yet
    assign first = !row_open;

    // Signed compare of Q4.4 scores
    assign max_new = (first || (in_score > row_max)) ? in_score : row_max;

    always_comb begin
        value_in = in_value;
        value_in[`VEC_LANES] = LANE_ONE;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tok_valid <= 1'b0;
            row_open <= 1'b0;
        end else if (take) begin
            tok_valid <= 1'b1;
            // Last token closes the row so the next one restarts the max
            row_open <= !in_last;
        end else if (tok_ready) begin
            tok_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            tok_score <= in_score;
            // On a first token both maxima equal the score
            tok_max_old <= first ? in_score : row_max;
            tok_max_new <= max_new;
            tok_value <= value_in;
            tok_first <= first;
            tok_last <= in_last;
            row_max <= max_new;
        end
    end

endmodule

`default_nettype wire

// File: source/expmul_stage.sv
// --------------------------------------------------
// Two-cycle v * exp(a - b) with a shift-only exp
// Expects a <= b so that L stays in 0..31
// --------------------------------------------------
`default_nettype none
`include "attn_cfg.svh"

module expmul_stage
    import attn_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      vld_in,
    output logic           rdy_out,
    output logic           vld_out,
    input  wire logic      rdy_in,
    input  wire score_t    a_in,
    input  wire score_t    b_in,
    input  wire lane_vec_t v_in,
    output lane_vec_t      v_out
);

    score_t    a_q;
    score_t    b_q;
    lane_vec_t v_s1;
    lane_vec_t v_s2;
    logic      s1_valid;
    logic      s2_valid;
    logic      s2_ready;
    logic      s1_load;
    logic      s2_load;
    diff_t     diff;
    log2e_t    t_val;
    log2e_t    l_round;
    shift_t    l_next;
    shift_t    l_q;

    // Stage 2 takes when empty or when the consumer drains it
    assign s2_ready = !s2_valid || rdy_in;
    assign rdy_out = !s1_valid || s2_ready;
    assign vld_out = s2_valid;
    assign s1_load = vld_in && rdy_out;
    assign s2_load = s1_valid && s2_ready;

    // Q5.4 difference of two Q4.4 scores
    assign diff = diff_t'(a_q) - diff_t'(b_q);

    // d * log2(e) as d + d/2 - d/16 in Q6.4
    assign t_val = log2e_t'(diff) + log2e_t'(diff >>> 1) - log2e_t'(diff >>> 4);

    // L = -t rounded half up to an integer
    assign l_round = (log2e_t'(8) - t_val) >>> 4;

    // Clamp into the 5-bit shift range
    always_comb begin
        if (l_round < 0) begin
            l_next = '0;
        end else if (l_round > 31) begin
            l_next = shift_t'(31);
        end else begin
            l_next = l_round[4:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else if (s1_load) begin
            s1_valid <= 1'b1;
        end else if (s2_ready) begin
            s1_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_load) begin
            a_q <= a_in;
            b_q <= b_in;
            v_s1 <= v_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
        end else if (s2_load) begin
            s2_valid <= 1'b1;
        end else if (rdy_in) begin
            s2_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (s2_load) begin
            l_q <= l_next;
            v_s2 <= v_s1;
        end
    end

    // Arithmetic barrel shift floors toward minus infinity
    always_comb begin : barrel_shift
        lane_t x;
        for (int i = 0; i <= `VEC_LANES; i++) begin
            x = v_s2[i];
            if (l_q[4]) x = x >>> 16;
            if (l_q[3]) x = x >>> 8;
            if (l_q[2]) x = x >>> 4;
            if (l_q[1]) x = x >>> 2;
            if (l_q[0]) x = x >>> 1;
            v_out[i] = x;
        end
    end

endmodule

`default_nettype wire

// File: source/row_accumulator.sv
// --------------------------------------------------
// Rescale-and-add recurrence over one softmax row
// One token in flight and lane sums wrap at LANE_W bits
// --------------------------------------------------
`default_nettype none
`include "attn_cfg.svh"

module row_accumulator
    import attn_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      tok_valid,
    output logic           tok_ready,
    input  wire score_t    tok_score,
    input  wire score_t    tok_max_old,
    input  wire score_t    tok_max_new,
    input  wire lane_vec_t tok_value,
    input  wire logic      tok_first,
    input  wire logic      tok_last,
    output logic           res_valid,
    input  wire logic      res_ready,
    output lane_vec_t      res_value
);

    acc_state_t state;
    lane_vec_t  acc;
    logic       last_q;
    logic       take;
    logic       rdy_tok;
    logic       rdy_acc;
    logic       vld_tok;
    logic       vld_acc;
    logic       sum_valid;
    logic       pipe_ready;
    lane_vec_t  acc_in;
    lane_vec_t  tok_scaled;
    lane_vec_t  acc_scaled;
    lane_vec_t  sum;

    // New tokens only while idle
    assign tok_ready = (state == IDLE) && rdy_tok && rdy_acc;
    assign take = tok_valid && tok_ready;

    // Start of row sees an empty accumulator
    assign acc_in = tok_first ? '0 : acc;

    // Both units run in lockstep
    assign sum_valid = vld_tok && vld_acc;
    assign pipe_ready = (state == BUSY) && sum_valid;

    assign res_valid = (state == HAND_OFF);
    assign res_value = acc;

    // Token weight exp(score - new max)
    expmul_stage u_tok_scale (
        .clk     (clk),
        .rst     (rst),
        .vld_in  (take),
        .rdy_out (rdy_tok),
        .vld_out (vld_tok),
        .rdy_in  (pipe_ready),
        .a_in    (tok_score),
        .b_in    (tok_max_new),
        .v_in    (tok_value),
        .v_out   (tok_scaled)
    );

    // Running sum rescaled by exp(old max - new max)
    expmul_stage u_acc_scale (
        .clk     (clk),
        .rst     (rst),
        .vld_in  (take),
        .rdy_out (rdy_acc),
        .vld_out (vld_acc),
        .rdy_in  (pipe_ready),
        .a_in    (tok_max_old),
        .b_in    (tok_max_new),
        .v_in    (acc_in),
        .v_out   (acc_scaled)
    );

    always_comb begin
        for (int i = 0; i <= `VEC_LANES; i++) begin
            sum[i] = tok_scaled[i] + acc_scaled[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            last_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (take) begin
                        state <= BUSY;
                        last_q <= tok_last;
                    end
                end
                BUSY: begin
                    // Sum lands at E+2
                    if (sum_valid) begin
                        state <= last_q ? HAND_OFF : IDLE;
                    end
                end
                HAND_OFF: begin
                    if (res_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Finished row stays in acc until handed off, then clears
    always_ff @(posedge clk) begin
        if (pipe_ready) begin
            acc <= sum;
        end else if (res_valid && res_ready) begin
            acc <= '0;
        end
    end

endmodule

`default_nettype wire

// File: source/result_emitter.sv
// --------------------------------------------------
// Output register holding one finished row result
// --------------------------------------------------
`default_nettype none

module result_emitter
    import attn_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      res_valid,
    output logic           res_ready,
    input  wire lane_vec_t res_value,
    output logic           out_valid,
    input  wire logic      out_ready,
    output lane_vec_t      out_value
);

    logic take;

    // Room when empty or the held row leaves now
    assign res_ready = !out_valid || out_ready;
    assign take = res_valid && res_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Held stable while the consumer stalls
    always_ff @(posedge clk) begin
        if (take) begin
            out_value <= res_value;
        end
    end

endmodule

`default_nettype wire

// File: source/attn_row_top.sv
// --------------------------------------------------
// Streaming softmax row accumulator without the final divide
// Top lane of out_value is the denominator
// --------------------------------------------------
`default_nettype none

module attn_row_top
    import attn_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      in_valid,
    output logic           in_ready,
    input  wire score_t    in_score,
    input  wire lane_vec_t in_value,
    input  wire logic      in_last,
    output logic           out_valid,
    input  wire logic      out_ready,
    output lane_vec_t      out_value
);

    logic      tok_valid;
    logic      tok_ready;
    score_t    tok_score;
    score_t    tok_max_old;
    score_t    tok_max_new;
    lane_vec_t tok_value;
    logic      tok_first;
    logic      tok_last;
    logic      res_valid;
    logic      res_ready;
    lane_vec_t res_value;

    token_intake u_intake (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_score    (in_score),
        .in_value    (in_value),
        .in_last     (in_last),
        .tok_valid   (tok_valid),
        .tok_ready   (tok_ready),
        .tok_score   (tok_score),
        .tok_max_old (tok_max_old),
        .tok_max_new (tok_max_new),
        .tok_value   (tok_value),
        .tok_first   (tok_first),
        .tok_last    (tok_last)
    );

    row_accumulator u_accum (
        .clk         (clk),
        .rst         (rst),
        .tok_valid   (tok_valid),
        .tok_ready   (tok_ready),
        .tok_score   (tok_score),
        .tok_max_old (tok_max_old),
        .tok_max_new (tok_max_new),
        .tok_value   (tok_value),
        .tok_first   (tok_first),
        .tok_last    (tok_last),
        .res_valid   (res_valid),
        .res_ready   (res_ready),
        .res_value   (res_value)
    );

    result_emitter u_emit (
        .clk       (clk),
        .rst       (rst),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_value (res_value),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_value (out_value)
    );

endmodule

`default_nettype wire

// File: verification/attn_row_assertions.sv
// --------------------------------------------------
// Handshake properties, bound into every attn_row_top
// --------------------------------------------------
`default_nettype none

module attn_row_assertions
    import attn_pkg::*;
(
    input wire logic      clk,
    input wire logic      rst,
    input wire logic      in_valid,
    input wire logic      in_ready,
    input wire score_t    in_score,
    input wire lane_vec_t in_value,
    input wire logic      in_last,
    input wire logic      out_valid,
    input wire logic      out_ready,
    input wire lane_vec_t out_value
);
    timeunit 1ns;
    timeprecision 100ps;

    // Offered token held until taken
    in_hold: assert property (@(posedge clk) disable iff (rst)
        in_valid && !in_ready |=>
            in_valid && $stable(in_score) && $stable(in_value) && $stable(in_last))
        else $error("Input token dropped or changed before its transfer");

    out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid)
        else $error("out_valid fell before its transfer");

    // Result frozen under back-pressure
    out_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> $stable(out_value))
        else $error("out_value changed while stalled");

    reset_idle: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    reset_ready: assert property (@(posedge clk) $fell(rst) |-> in_ready && !out_valid)
        else $error("Intake not ready or output busy right after reset");

endmodule

bind attn_row_top attn_row_assertions u_assertions (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_score  (in_score),
    .in_value  (in_value),
    .in_last   (in_last),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_value (out_value)
);

`default_nettype wire

// File: verification/attn_row_tb.sv
// --------------------------------------------------
// Token and expected-row records come from verification/attn_row_stimulus.txt
// Run from the project root; the first error ends the run with $fatal
// --------------------------------------------------
`default_nettype none
`include "attn_cfg.svh"

module attn_row_tb
    import attn_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // Eight hex words per record, see the data file
    localparam int REC_WORDS = 8;
    localparam int MAX_RECORDS = 32;
    localparam int WAIT_LIMIT = 100;
    localparam int RESULT_LIMIT = 200;
    localparam int TAIL_CYCLES = 16;

    logic      clk = 1'b0;
    logic      rst;
    logic      in_valid;
    logic      in_ready;
    score_t    in_score;
    lane_vec_t in_value;
    logic      in_last;
    logic      out_valid;
    logic      out_ready;
    lane_vec_t out_value;

    logic [31:0] stim_mem [0:REC_WORDS*MAX_RECORDS-1];
    score_t      tok_scores [$];
    logic        tok_lasts [$];
    lane_vec_t   tok_values [$];
    lane_vec_t   exp_values [$];
    int          gap_cycles [$];
    logic [31:0] lfsr_state;

    attn_row_top UUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_score  (in_score),
        .in_value  (in_value),
        .in_last   (in_last),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_value (out_value)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1, new bit enters at the bottom
    function automatic logic [31:0] lfsr_advance(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0d ns: %s expected %h actual %h",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    // Splits the file into a token queue and an expected-row queue
    task automatic load_stimulus();
        int        rec;
        int        base;
        logic      done;
        lane_vec_t v;
        $readmemh("verification/attn_row_stimulus.txt", stim_mem);
        done = 1'b0;
        rec = 0;
        while (!done) begin
            if (rec >= MAX_RECORDS) begin
                $display("Stimulus file has no end record in its first %0d records",
                         MAX_RECORDS);
                abort_run();
            end
            base = rec * REC_WORDS;
            for (int i = 0; i <= `VEC_LANES; i++) begin
                v[i] = stim_mem[base + 3 + i][`LANE_W-1:0];
            end
            case (stim_mem[base])
                32'h1: begin
                    tok_scores.push_back(stim_mem[base + 1][`SCORE_W-1:0]);
                    tok_lasts.push_back(stim_mem[base + 2][0]);
                    tok_values.push_back(v);
                end
                32'h2: exp_values.push_back(v);
                32'hF: done = 1'b1;
                default: begin
                    $display("Stimulus record %0d has an unknown kind", rec);
                    abort_run();
                end
            endcase
            rec++;
        end
    endtask

    // Idle gap, then hold the token until in_ready
    task automatic send_tokens();
        int waited;
        for (int k = 0; k < tok_scores.size(); k++) begin
            repeat (gap_cycles[k]) begin
                @(posedge clk);
                #1;
            end
            in_valid = 1'b1;
            in_score = tok_scores[k];
            in_value = tok_values[k];
            in_last = tok_lasts[k];
            waited = 0;
            @(negedge clk);
            while (!in_ready) begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    $display("Timeout: in_ready stayed low while token %0d was offered", k);
                    abort_run();
                end
                @(negedge clk);
            end
            @(posedge clk);
            #1;
            in_valid = 1'b0;
        end
    endtask

    // Sampled mid-cycle, a transfer lands on the next rising edge
    task automatic collect_results();
        int        got;
        int        idle;
        logic      stalled;
        lane_vec_t held;
        lane_vec_t want;
        got = 0;
        idle = 0;
        stalled = 1'b0;
        held = '0;
        while (got < exp_values.size()) begin
            @(negedge clk);
            idle++;
            if (idle > RESULT_LIMIT) begin
                $display("Timeout: row result %0d never appeared on out_valid", got);
                abort_run();
            end
            if (stalled) begin
                check_equal("out_valid while stalled", 32'd1, 32'(out_valid));
                for (int i = 0; i <= `VEC_LANES; i++) begin
                    check_equal($sformatf("out_value[%0d] while stalled", i),
                                32'(held[i]), 32'(out_value[i]));
                end
            end
            if (out_valid && out_ready) begin
                want = exp_values[got];
                // Top lane carries the denominator
                for (int i = 0; i <= `VEC_LANES; i++) begin
                    check_equal($sformatf("row %0d out_value[%0d]", got, i),
                                32'(want[i]), 32'(out_value[i]));
                end
                got++;
                idle = 0;
                stalled = 1'b0;
            end else begin
                stalled = out_valid;
                held = out_value;
            end
        end
    endtask

    // Gap table first, then a random out_ready every cycle
    initial begin : ready_toggle
        lfsr_state = 32'h42fa_030f;
        out_ready = 1'b0;
        for (int k = 0; k < MAX_RECORDS; k++) begin
            lfsr_state = lfsr_advance(lfsr_state);
            lfsr_state = lfsr_advance(lfsr_state);
            gap_cycles.push_back(int'(lfsr_state[1:0]));
        end
        forever begin
            @(posedge clk);
            #1;
            lfsr_state = lfsr_advance(lfsr_state);
            out_ready = lfsr_state[0];
        end
    end

    initial begin : main
        rst = 1'b1;
        in_valid = 1'b0;
        in_score = '0;
        in_value = '0;
        in_last = 1'b0;
        load_stimulus();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        // Idle outputs just out of reset
        @(negedge clk);
        check_equal("out_valid after reset", 32'd0, 32'(out_valid));
        check_equal("in_ready after reset", 32'd1, 32'(in_ready));
        @(posedge clk);
        #1;
        fork
            send_tokens();
            collect_results();
        join
        // No extra row may follow the last expected one
        repeat (TAIL_CYCLES) begin
            @(negedge clk);
            check_equal("out_valid after the last row", 32'd0, 32'(out_valid));
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/attn_row_stimulus.txt
// kind score last lane0 lane1 lane2 lane3 lane4 (kind 1 token, 2 expected row, F end)
// Lanes are 26-bit Q9.17 hex; token lane4 is ignored and expected lane4 is the denominator
// Row 1 is a single token so L is 0
1 10 1 0020000 3FE0000 0012345 3FF8001 1234567
2 00 0 0020000 3FE0000 0012345 3FF8001 0020000
// Row 2 with rising scores 0 then 1.0 then 3.0
1 00 0 0040000 3FC0000 0010000 0000007 0000000
1 10 0 0020000 0008000 3FF0000 0000000 0000000
1 30 1 0010000 0020000 0000000 3FFFFF0 3FFFFFF
2 00 0 0018000 001D000 3FFF000 3FFFFF0 0026000
// Row 3 with falling scores 2.0 then 0 then -2.0
1 20 0 0020000 0020000 3FE0000 0001000 0000000
1 00 0 0040000 3FC0000 0040000 0000000 0000000
1 E0 1 0100000 0100000 3F00000 0000040 0000000
2 00 0 002C000 001C000 3FE4000 0001001 0024800
// Row 4 jumps from -8.0 to 7.9375 so the old sum shifts by 23
1 80 0 0123456 3FEDCBA 07FFFFF 3800000 0000000
1 7F 1 0020000 0020000 3FE0000 0000000 0000000
2 00 0 0020000 001FFFF 3FE0000 3FFFFFF 0020000
// Row 5 with scores 0.5 then 2.5 then 1.5
1 08 0 0080000 3F80000 0000100 0000003 0000000
1 28 0 0000000 0010000 0020000 3FFFFFC 0000000
1 18 1 0040000 0040000 3FC0000 0000002 0000000
2 00 0 0030000 0020000 0000020 3FFFFFD 0034000
F 00 0 0000000 0000000 0000000 0000000 0000000

// File: project.f
+incdir+source
source/attn_pkg.sv
source/token_intake.sv
source/expmul_stage.sv
source/row_accumulator.sv
source/result_emitter.sv
source/attn_row_top.sv
verification/attn_row_assertions.sv
verification/attn_row_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the attn_row testbench with Verilator from the project root.
# The exit status is the simulator's own, nonzero when a check fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module attn_row_tb -f project.f -o attn_row_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status" >&2
    exit "$status"
fi

./obj_dir/attn_row_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status" >&2
fi
exit "$status"
